// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ADC controller testbench with Verilator.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_adc_ctrl -o Vtb_adc_ctrl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_adc_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: src.f
verilog/adc_ctrl_pkg.sv
verilog/opb_adc_regs.sv
verilog/adc_serial_config.sv
verilog/adc_reset_gen.sv
verilog/adc_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/adc_ctrl_asserts.sv
testbench/tb_adc_ctrl.sv

// File: testbench/adc_ctrl_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module adc_ctrl_asserts #(
  parameter int unsigned sclk_div_log2 = 4
) (
  input wire logic OPB_Clk,
  input wire logic rst_n,
  input wire logic sl_xferack,
  input wire logic adc0_psen,
  input wire logic adc1_psen,
  input wire logic adc0_strobe,
  input wire logic adc1_strobe,
  input wire logic adc0_sclk,
  input wire logic adc1_sclk,
  input wire logic adc0_adc_reset,
  input wire logic adc1_adc_reset,
  input wire logic adc0_dcm_reset,
  input wire logic adc1_dcm_reset
);

  localparam int unsigned half_period = 2 ** (sclk_div_log2 - 1);

  a_ack_single: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    sl_xferack |=> !sl_xferack) else $error("sl_xferack high for two cycles");

  a_psen0_pulse: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    adc0_psen |=> !adc0_psen) else $error("adc0_psen high for two cycles");
  a_psen1_pulse: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    adc1_psen |=> !adc1_psen) else $error("adc1_psen high for two cycles");

  // A running serial clock flips every half bit period.
  a_strobe0: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    !adc0_strobe |-> adc0_sclk != $past(adc0_sclk, half_period))
    else $error("adc0 strobe low while sclk stopped");
  a_strobe1: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    !adc1_strobe |-> adc1_sclk != $past(adc1_sclk, half_period))
    else $error("adc1 strobe low while sclk stopped");

  a_dcm0: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    adc0_adc_reset |=> adc0_dcm_reset) else $error("adc0 DCM reset missing");
  a_dcm1: assert property (@(posedge OPB_Clk) disable iff (!rst_n)
    adc1_adc_reset |=> adc1_dcm_reset) else $error("adc1 DCM reset missing");

endmodule

`default_nettype wire

// File: testbench/tb_adc_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_adc_ctrl;

  localparam logic [31:0] BASE        = 32'h0001_0000;
  localparam int          DCM_CYCLES  = 255;
  localparam int          NUM_ENTRIES = 23;
  localparam logic [31:0] CFG_MASK    = 32'hFFFF_0F00;
  localparam logic [3:0]  OP_WR = 4'd0, OP_RD = 4'd1, OP_FRAME = 4'd2, OP_DUAL = 4'd3;
  localparam logic [3:0]  OP_RESET = 4'd4, OP_RANGE = 4'd5, OP_PS = 4'd6;

  typedef struct packed {
    logic [3:0]  op;
    logic [31:0] offset;
    logic [3:0]  be;
    logic        rnd;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [31:0] mask;
    logic [1:0]  psdone;
  } entry_t;

  logic OPB_Clk, rst_n;
  logic [0:31] opb_abus, opb_dbus, sl_dbus;
  logic [0:3]  opb_be;
  logic opb_rnw, opb_select, sl_xferack;
  logic adc0_sclk, adc0_sdata, adc0_strobe, adc0_adc_reset, adc0_dcm_reset;
  logic adc0_psen, adc0_psincdec, adc0_psdone;
  logic adc1_sclk, adc1_sdata, adc1_strobe, adc1_adc_reset, adc1_dcm_reset;
  logic adc1_psen, adc1_psincdec, adc1_psdone;

  entry_t      table_q [NUM_ENTRIES];
  logic [31:0] cfg_model [2];
  int          rx_total0, rx_total1;
  logic [31:0] rx_shift0, rx_shift1;

  tb_clock_gen u_clk (.clk(OPB_Clk), .rst_n(rst_n));

  adc_ctrl_top #(.base_addr(BASE)) dut0 (.*);

  bind adc_ctrl_top adc_ctrl_asserts u_asserts (.*);

  // Serial frame decoders, sampling where the ADC does.
  always @(posedge adc0_sclk) begin
    if (!adc0_strobe) begin
      rx_shift0 = {rx_shift0[30:0], adc0_sdata};
      rx_total0++;
    end
  end

  always @(posedge adc1_sclk) begin
    if (!adc1_strobe) begin
      rx_shift1 = {rx_shift1[30:0], adc1_sdata};
      rx_total1++;
    end
  end

  initial begin
    repeat (NUM_ENTRIES * 700 + 1000) @(posedge OPB_Clk);
    $display("Timeout: the test did not finish in the allowed time");
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic value_error(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic entry_t make_entry(input logic [3:0] op, input logic [31:0] offset,
      input logic [3:0] be, input logic rnd, input logic [31:0] wdata,
      input logic [31:0] exp, input logic [31:0] mask, input logic [1:0] psdone);
    return '{op, offset, be, rnd, wdata, exp, mask, psdone};
  endfunction

  // Header of value 1, then address, then data.
  function automatic logic [31:0] expected_frame(input logic [31:0] w);
    return {12'h001, w[11:8], w[31:16]};
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [3:0] be,
      input logic [31:0] w);
    logic [31:0] res;
    res = old;
    for (int k = 0; k < 4; k++) begin
      if (be[3-k]) res[31-8*k -: 8] = w[31-8*k -: 8];
    end
    return res & CFG_MASK;
  endfunction

  task automatic bus_access(input logic rnw, input logic [31:0] offset, input logic [3:0] be,
      input logic [31:0] wdata, output logic [31:0] rdata);
    int late;
    late = 0;
    @(posedge OPB_Clk);
    #1;
    opb_abus   = BASE + offset;
    opb_be     = be;
    opb_dbus   = rnw ? 32'h0 : wdata;
    opb_rnw    = rnw;
    opb_select = 1'b1;
    @(posedge OPB_Clk);
    #1;
    while (!sl_xferack) begin
      late++;
      @(posedge OPB_Clk);
      #1;
    end
    assert (late == 0) else value_error($sformatf("ack %0d cycles late", late));
    rdata      = sl_dbus;
    opb_select = 1'b0;
    opb_rnw    = 1'b1;
    opb_be     = '0;
    opb_dbus   = '0;
  endtask

  task automatic bus_write(input logic [31:0] offset, input logic [3:0] be,
      input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b0, offset, be, wdata, unused);
  endtask

  task automatic check_read(input logic [31:0] offset, input logic [31:0] exp,
      input logic [31:0] mask, output logic [31:0] rd);
    bus_access(1'b1, offset, 4'b1111, 32'h0, rd);
    assert ((rd & mask) == (exp & mask)) else
      value_error($sformatf("offset %h read %h expected %h", offset, rd, exp & mask));
  endtask

  task automatic wait_done(input int ch);
    logic [31:0] rd;
    rd = '0;
    while (rd[0] == 1'b0) begin
      check_read(ch ? 32'h8 : 32'h4, cfg_model[ch], CFG_MASK, rd);
    end
  endtask

  task automatic check_frame(input int ch, input int start, input logic [31:0] w);
    int count;
    logic [31:0] got;
    count = (ch ? rx_total1 : rx_total0) - start;
    got   = ch ? rx_shift1 : rx_shift0;
    assert (count == 32) else value_error($sformatf("ch%0d sampled %0d bits", ch, count));
    assert (got == expected_frame(w)) else
      value_error($sformatf("ch%0d frame %h expected %h", ch, got, expected_frame(w)));
    assert ((ch ? adc1_strobe : adc0_strobe) == 1'b1) else
      value_error($sformatf("ch%0d strobe low after frame", ch));
  endtask

  task automatic run_frame(input int ch);
    logic [31:0] w, rd;
    int start;
    w     = $urandom & CFG_MASK;
    start = ch ? rx_total1 : rx_total0;
    bus_write(ch ? 32'h8 : 32'h4, 4'b1111, w | 32'h1);
    cfg_model[ch] = w;
    assert ((ch ? adc1_strobe : adc0_strobe) == 1'b1) else
      value_error($sformatf("ch%0d strobe low before data phase", ch));
    check_read(ch ? 32'h8 : 32'h4, w, CFG_MASK | 32'h1, rd);
    wait_done(ch);
    check_frame(ch, start, w);
  endtask

  task automatic run_dual();
    logic [31:0] w0, w1, w2;
    int s0, s1;
    w0 = $urandom & CFG_MASK;
    w1 = $urandom & CFG_MASK;
    w2 = $urandom & CFG_MASK;
    s0 = rx_total0;
    s1 = rx_total1;
    bus_write(32'h4, 4'b1111, w0 | 32'h1);
    repeat (3) @(posedge OPB_Clk);
    bus_write(32'h8, 4'b1111, w1 | 32'h1);
    // Channel 0 is busy, so this start is dropped.
    bus_write(32'h4, 4'b1111, w2 | 32'h1);
    cfg_model[0] = w2;
    cfg_model[1] = w1;
    wait_done(0);
    wait_done(1);
    check_frame(0, s0, w0);
    check_frame(1, s1, w1);
  endtask

  task automatic run_reset(input logic [31:0] wdata);
    int ch, n;
    ch = wdata[0] ? 0 : 1;
    bus_write(32'h0, 4'b0001, wdata);
    @(posedge OPB_Clk);
    #1;
    assert ((ch ? adc1_adc_reset : adc0_adc_reset) && !(ch ? adc0_adc_reset : adc1_adc_reset))
      else value_error($sformatf("adc%0d reset not asserted one cycle after ack", ch));
    n = 0;
    do begin
      @(posedge OPB_Clk);
      #1;
      n++;
      if (n == 1) begin
        assert (!(ch ? adc1_adc_reset : adc0_adc_reset)) else
          value_error($sformatf("adc%0d reset longer than one cycle", ch));
      end
    end while (ch ? adc1_dcm_reset : adc0_dcm_reset);
    assert (n == DCM_CYCLES) else value_error($sformatf("ch%0d dcm_reset fell after %0d", ch, n));
  endtask

  task automatic run_ps(input logic [31:0] wdata);
    bus_write(32'h0, 4'b0100, wdata);
    assert (adc0_psen == wdata[16] && adc1_psen == wdata[20]) else
      value_error("psen pulse missing or wrong channel");
    assert (adc0_psincdec == wdata[17] && adc1_psincdec == wdata[21]) else
      value_error("psincdec level wrong");
    @(posedge OPB_Clk);
    #1;
    assert (!adc0_psen && !adc1_psen) else value_error("psen longer than one cycle");
  endtask

  task automatic run_range(input logic [31:0] offset);
    @(posedge OPB_Clk);
    #1;
    opb_abus   = BASE + offset;
    opb_rnw    = 1'b1;
    opb_be     = 4'b1111;
    opb_select = 1'b1;
    repeat (20) begin
      @(posedge OPB_Clk);
      #1;
      assert (!sl_xferack && sl_dbus == '0) else
        value_error($sformatf("out-of-range address %h acknowledged", BASE + offset));
    end
    opb_select = 1'b0;
  endtask

  task automatic load_table();
    table_q[0]  = make_entry(OP_WR, 32'h4, 4'b1111, 1'b1, 0, 0, 0, 2'b00);
    table_q[1]  = make_entry(OP_WR, 32'h8, 4'b1111, 1'b1, 0, 0, 0, 2'b00);
    table_q[2]  = make_entry(OP_RD, 32'h4, 4'b1111, 1'b0, 0, 0, 32'hFFFF_0F01, 2'b00);
    table_q[3]  = make_entry(OP_RD, 32'h8, 4'b1111, 1'b0, 0, 0, 32'hFFFF_0F01, 2'b00);
    table_q[4]  = make_entry(OP_WR, 32'h4, 4'b0010, 1'b1, 0, 0, 0, 2'b00);
    table_q[5]  = make_entry(OP_WR, 32'h4, 4'b1000, 1'b1, 0, 0, 0, 2'b00);
    table_q[6]  = make_entry(OP_RD, 32'h4, 4'b1111, 1'b0, 0, 0, 32'hFFFF_0F01, 2'b00);
    table_q[7]  = make_entry(OP_WR, 32'h8, 4'b0100, 1'b1, 0, 0, 0, 2'b00);
    table_q[8]  = make_entry(OP_RD, 32'h8, 4'b1111, 1'b0, 0, 0, 32'hFFFF_0F01, 2'b00);
    table_q[9]  = make_entry(OP_RD, 32'hC, 4'b1111, 1'b0, 0, 0, 32'hFFFF_FFFF, 2'b11);
    table_q[10] = make_entry(OP_RANGE, 32'hFFFF_FFF0, 0, 1'b0, 0, 0, 0, 2'b11);
    table_q[11] = make_entry(OP_RANGE, 32'h0000_0010, 0, 1'b0, 0, 0, 0, 2'b11);
    table_q[12] = make_entry(OP_FRAME, 32'h4, 0, 1'b0, 0, 0, 0, 2'b00);
    table_q[13] = make_entry(OP_FRAME, 32'h8, 0, 1'b0, 0, 0, 0, 2'b00);
    table_q[14] = make_entry(OP_DUAL, 0, 0, 1'b0, 0, 0, 0, 2'b00);
    table_q[15] = make_entry(OP_RESET, 0, 0, 1'b0, 32'h1, 0, 0, 2'b00);
    table_q[16] = make_entry(OP_RESET, 0, 0, 1'b0, 32'h2, 0, 0, 2'b00);
    table_q[17] = make_entry(OP_PS, 0, 0, 1'b0, 32'h0003_0000, 0, 0, 2'b00);
    table_q[18] = make_entry(OP_RD, 0, 0, 1'b0, 0, 32'h0002_0000, 32'hFFFF_FFFF, 2'b00);
    table_q[19] = make_entry(OP_PS, 0, 0, 1'b0, 32'h0030_0000, 0, 0, 2'b00);
    table_q[20] = make_entry(OP_RD, 0, 0, 1'b0, 0, 32'h1020_0000, 32'hFFFF_FFFF, 2'b10);
    table_q[21] = make_entry(OP_RD, 0, 0, 1'b0, 0, 32'h3020_0000, 32'hFFFF_FFFF, 2'b11);
    table_q[22] = make_entry(OP_RD, 0, 0, 1'b0, 0, 32'h2020_0000, 32'hFFFF_FFFF, 2'b01);
  endtask

  initial begin
    entry_t      e;
    logic [31:0] w, rd, exp;
    int          ch, n;
    opb_abus    = '0;
    opb_be      = '0;
    opb_dbus    = '0;
    opb_rnw     = 1'b1;
    opb_select  = 1'b0;
    adc0_psdone = 1'b0;
    adc1_psdone = 1'b0;
    void'($urandom(32'h893a6ece));
    load_table();

    // DCM reset stretch after rst_n release.
    wait (rst_n === 1'b1);
    assert (adc0_adc_reset && adc1_adc_reset) else value_error("adc_reset low out of reset");
    n = 0;
    do begin
      @(posedge OPB_Clk);
      #1;
      n++;
      if (n == 1) begin
        assert (!adc0_adc_reset && !adc1_adc_reset) else value_error("adc_reset stuck high");
      end
    end while (adc0_dcm_reset);
    assert (n == DCM_CYCLES && !adc1_dcm_reset) else
      value_error($sformatf("dcm_reset after rst_n lasted %0d cycles", n));

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      e  = table_q[i];
      ch = (e.offset == 32'h8) ? 1 : 0;
      @(posedge OPB_Clk);
      #1;
      adc0_psdone = e.psdone[1];
      adc1_psdone = e.psdone[0];
      case (e.op)
        OP_WR: begin
          w = e.rnd ? $urandom & CFG_MASK : e.wdata;
          bus_write(e.offset, e.be, w);
          cfg_model[ch] = merge_lanes(cfg_model[ch], e.be, w);
        end
        OP_RD: begin
          exp = (e.offset == 32'h4 || e.offset == 32'h8) ? (cfg_model[ch] | 32'h1) : e.exp;
          check_read(e.offset, exp, e.mask, rd);
        end
        OP_FRAME: run_frame(ch);
        OP_DUAL:  run_dual();
        OP_RESET: run_reset(e.wdata);
        OP_RANGE: run_range(e.offset);
        OP_PS:    run_ps(e.wdata);
        default:  value_error($sformatf("unknown table operation in entry %0d", i));
      endcase
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);

  // 100 ns period.
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: verilog/adc_ctrl_pkg.sv
`default_nettype none

package adc_ctrl_pkg;

  // Serializer states.
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    CLKWAIT = 2'd1,
    DATA    = 2'd2,
    FINISH  = 2'd3
  } config_state_e;

  // Register index, taken from offset bits 28 and 29 of the bus address.
  typedef enum logic [1:0] {
    REG_CTRL  = 2'd0,
    REG_CFG0  = 2'd1,
    REG_CFG1  = 2'd2,
    REG_SPARE = 2'd3
  } reg_sel_e;

  // ADC serial frame layout.
  localparam int unsigned CFG_ADDR_BITS  = 4;
  localparam int unsigned CFG_DATA_BITS  = 16;
  localparam int unsigned CFG_FRAME_BITS = 32;
  localparam int unsigned CFG_HDR_BITS   = CFG_FRAME_BITS - CFG_ADDR_BITS - CFG_DATA_BITS;

endpackage

`default_nettype wire

// File: verilog/adc_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module adc_ctrl_top import adc_ctrl_pkg::*; #(
  parameter logic [31:0] base_addr        = 32'h0001_0000,
  parameter logic [31:0] high_addr        = 32'h0001_000F,
  parameter int unsigned sclk_div_log2    = 4,
  parameter int unsigned dcm_reset_cycles = 255
) (
  input  wire logic        OPB_Clk,
  input  wire logic        rst_n,
  input  wire logic [0:31] opb_abus,
  input  wire logic [0:3]  opb_be,
  input  wire logic [0:31] opb_dbus,
  input  wire logic        opb_rnw,
  input  wire logic        opb_select,
  output logic      [0:31] sl_dbus,
  output logic             sl_xferack,
  output logic             adc0_sclk,
  output logic             adc0_sdata,
  output logic             adc0_strobe,
  output logic             adc0_adc_reset,
  output logic             adc0_dcm_reset,
  output logic             adc0_psen,
  output logic             adc0_psincdec,
  input  wire logic        adc0_psdone,
  output logic             adc1_sclk,
  output logic             adc1_sdata,
  output logic             adc1_strobe,
  output logic             adc1_adc_reset,
  output logic             adc1_dcm_reset,
  output logic             adc1_psen,
  output logic             adc1_psincdec,
  input  wire logic        adc1_psdone
);

  logic                     adc0_reset_req;
  logic                     adc1_reset_req;
  logic                     cfg0_start;
  logic [CFG_ADDR_BITS-1:0] cfg0_addr;
  logic [CFG_DATA_BITS-1:0] cfg0_data;
  logic                     cfg0_done;
  logic                     cfg1_start;
  logic [CFG_ADDR_BITS-1:0] cfg1_addr;
  logic [CFG_DATA_BITS-1:0] cfg1_data;
  logic                     cfg1_done;

  opb_adc_regs #(
    .base_addr (base_addr),
    .high_addr (high_addr)
  ) u_regs (
    .OPB_Clk        (OPB_Clk),
    .rst_n          (rst_n),
    .opb_abus       (opb_abus),
    .opb_be         (opb_be),
    .opb_dbus       (opb_dbus),
    .opb_rnw        (opb_rnw),
    .opb_select     (opb_select),
    .sl_dbus        (sl_dbus),
    .sl_xferack     (sl_xferack),
    .adc0_reset_req (adc0_reset_req),
    .adc1_reset_req (adc1_reset_req),
    .adc0_psen      (adc0_psen),
    .adc0_psincdec  (adc0_psincdec),
    .adc1_psen      (adc1_psen),
    .adc1_psincdec  (adc1_psincdec),
    .adc0_psdone    (adc0_psdone),
    .adc1_psdone    (adc1_psdone),
    .cfg0_start     (cfg0_start),
    .cfg0_addr      (cfg0_addr),
    .cfg0_data      (cfg0_data),
    .cfg1_start     (cfg1_start),
    .cfg1_addr      (cfg1_addr),
    .cfg1_data      (cfg1_data),
    .cfg0_done      (cfg0_done),
    .cfg1_done      (cfg1_done)
  );

  adc_serial_config #(
    .sclk_div_log2 (sclk_div_log2)
  ) u_cfg0 (
    .OPB_Clk   (OPB_Clk),
    .rst_n     (rst_n),
    .cfg_start (cfg0_start),
    .cfg_addr  (cfg0_addr),
    .cfg_data  (cfg0_data),
    .cfg_done  (cfg0_done),
    .sclk      (adc0_sclk),
    .sdata     (adc0_sdata),
    .strobe    (adc0_strobe)
  );

  adc_serial_config #(
    .sclk_div_log2 (sclk_div_log2)
  ) u_cfg1 (
    .OPB_Clk   (OPB_Clk),
    .rst_n     (rst_n),
    .cfg_start (cfg1_start),
    .cfg_addr  (cfg1_addr),
    .cfg_data  (cfg1_data),
    .cfg_done  (cfg1_done),
    .sclk      (adc1_sclk),
    .sdata     (adc1_sdata),
    .strobe    (adc1_strobe)
  );

  adc_reset_gen #(
    .dcm_reset_cycles (dcm_reset_cycles)
  ) u_rst0 (
    .OPB_Clk   (OPB_Clk),
    .rst_n     (rst_n),
    .reset_req (adc0_reset_req),
    .adc_reset (adc0_adc_reset),
    .dcm_reset (adc0_dcm_reset)
  );

  adc_reset_gen #(
    .dcm_reset_cycles (dcm_reset_cycles)
  ) u_rst1 (
    .OPB_Clk   (OPB_Clk),
    .rst_n     (rst_n),
    .reset_req (adc1_reset_req),
    .adc_reset (adc1_adc_reset),
    .dcm_reset (adc1_dcm_reset)
  );

endmodule

`default_nettype wire

// File: verilog/adc_reset_gen.sv
`timescale 1ns/100ps
`default_nettype none

module adc_reset_gen #(
  parameter int unsigned dcm_reset_cycles = 255
) (
  input  wire logic OPB_Clk,
  input  wire logic rst_n,
  input  wire logic reset_req,
  output logic      adc_reset,
  output logic      dcm_reset
);

  logic [7:0] dcm_cnt;

  // Output flop, intended to sit in the I/O cell.
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      adc_reset <= 1'b1;
    end else begin
      adc_reset <= reset_req;
    end
  end

  // Hold the DCM in reset while the ADC clock settles.
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      dcm_cnt <= 8'(dcm_reset_cycles);
    end else if (reset_req) begin
      dcm_cnt <= 8'(dcm_reset_cycles);
    end else if (dcm_cnt != 8'd0) begin
      dcm_cnt <= dcm_cnt - 8'd1;
    end
  end

  assign dcm_reset = (dcm_cnt != 8'd0);

endmodule

`default_nettype wire

// File: verilog/adc_serial_config.sv
`timescale 1ns/100ps
`default_nettype none

module adc_serial_config import adc_ctrl_pkg::*; #(
  parameter int unsigned sclk_div_log2 = 4
) (
  input  wire logic                     OPB_Clk,
  input  wire logic                     rst_n,
  input  wire logic                     cfg_start,
  input  wire logic [CFG_ADDR_BITS-1:0] cfg_addr,
  input  wire logic [CFG_DATA_BITS-1:0] cfg_data,
  output logic                          cfg_done,
  output logic                          sclk,
  output logic                          sdata,
  output logic                          strobe
);

  localparam int unsigned BIT_CNT_W = $clog2(CFG_FRAME_BITS);

  config_state_e             state;
  logic [sclk_div_log2-1:0]  div_cnt;
  logic                      tick;
  logic [BIT_CNT_W-1:0]      bit_cnt;
  logic [CFG_FRAME_BITS-1:0] shift_reg;

  // Divider runs only while a frame is in progress.
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (state != IDLE) begin
      div_cnt <= div_cnt + 1'b1;
    end else begin
      div_cnt <= '0;
    end
  end

  // End of one bit period.
  assign tick = &div_cnt;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (cfg_start) begin
            state <= CLKWAIT;
          end
        end
        CLKWAIT: begin
          if (tick) begin
            state   <= DATA;
            bit_cnt <= '0;
          end
        end
        DATA: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_CNT_W'(CFG_FRAME_BITS - 1)) begin
              state <= FINISH;
            end
          end
        end
        FINISH: begin
          if (tick) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Header of value 1, then address, then data, MSB first.
  always_ff @(posedge OPB_Clk) begin
    if (state == IDLE && cfg_start) begin
      shift_reg <= {CFG_HDR_BITS'(1), cfg_addr, cfg_data};
    end else if (state == DATA && tick) begin
      shift_reg <= shift_reg << 1;
    end
  end

  assign cfg_done = (state == IDLE);
  // Rises at mid-period, where the ADC samples.
  assign sclk     = div_cnt[sclk_div_log2-1];
  assign sdata    = shift_reg[CFG_FRAME_BITS-1];
  assign strobe   = (state != DATA);

endmodule

`default_nettype wire

// File: verilog/opb_adc_regs.sv
`timescale 1ns/100ps
`default_nettype none

module opb_adc_regs import adc_ctrl_pkg::*; #(
  parameter logic [31:0] base_addr = 32'h0001_0000,
  parameter logic [31:0] high_addr = 32'h0001_000F
) (
  input  wire logic                     OPB_Clk,
  input  wire logic                     rst_n,
  input  wire logic [0:31]              opb_abus,
  input  wire logic [0:3]               opb_be,
  input  wire logic [0:31]              opb_dbus,
  input  wire logic                     opb_rnw,
  input  wire logic                     opb_select,
  output logic      [0:31]              sl_dbus,
  output logic                          sl_xferack,
  output logic                          adc0_reset_req,
  output logic                          adc1_reset_req,
  output logic                          adc0_psen,
  output logic                          adc0_psincdec,
  output logic                          adc1_psen,
  output logic                          adc1_psincdec,
  input  wire logic                     adc0_psdone,
  input  wire logic                     adc1_psdone,
  output logic                          cfg0_start,
  output logic      [CFG_ADDR_BITS-1:0] cfg0_addr,
  output logic      [CFG_DATA_BITS-1:0] cfg0_data,
  output logic                          cfg1_start,
  output logic      [CFG_ADDR_BITS-1:0] cfg1_addr,
  output logic      [CFG_DATA_BITS-1:0] cfg1_data,
  input  wire logic                     cfg0_done,
  input  wire logic                     cfg1_done
);

  logic [0:31] addr_off;
  reg_sel_e    reg_sel;
  logic        in_range;
  logic        ack_now;
  logic        wr_en;
  logic [0:31] rd_word;

  assign in_range = opb_select && (opb_abus >= base_addr) && (opb_abus <= high_addr);
  assign addr_off = opb_abus - base_addr;
  // Big-endian bits 28 and 29 select the word.
  assign reg_sel  = reg_sel_e'(addr_off[28:29]);

  // Acknowledge only when not already acknowledging, so each cycle gets one.
  assign ack_now  = in_range && !sl_xferack;
  assign wr_en    = ack_now && !opb_rnw;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      sl_xferack     <= 1'b0;
      adc0_reset_req <= 1'b0;
      adc1_reset_req <= 1'b0;
      adc0_psen      <= 1'b0;
      adc1_psen      <= 1'b0;
      adc0_psincdec  <= 1'b0;
      adc1_psincdec  <= 1'b0;
      cfg0_start     <= 1'b0;
      cfg1_start     <= 1'b0;
    end else begin
      sl_xferack     <= ack_now;
      // Pulse fields last one cycle.
      adc0_reset_req <= 1'b0;
      adc1_reset_req <= 1'b0;
      adc0_psen      <= 1'b0;
      adc1_psen      <= 1'b0;
      cfg0_start     <= 1'b0;
      cfg1_start     <= 1'b0;
      if (wr_en) begin
        case (reg_sel)
          REG_CTRL: begin
            if (opb_be[3]) begin
              adc0_reset_req <= opb_dbus[31];
              adc1_reset_req <= opb_dbus[30];
            end
            if (opb_be[1]) begin
              adc0_psen     <= opb_dbus[15];
              adc0_psincdec <= opb_dbus[14];
              adc1_psen     <= opb_dbus[11];
              adc1_psincdec <= opb_dbus[10];
            end
          end
          REG_CFG0: begin
            if (opb_be[3]) begin
              cfg0_start <= opb_dbus[31];
            end
          end
          REG_CFG1: begin
            if (opb_be[3]) begin
              cfg1_start <= opb_dbus[31];
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Frame words, one lane at a time.
  always_ff @(posedge OPB_Clk) begin
    if (wr_en && reg_sel == REG_CFG0) begin
      if (opb_be[2]) begin
        cfg0_addr <= opb_dbus[20:23];
      end
      if (opb_be[1]) begin
        cfg0_data[7:0] <= opb_dbus[8:15];
      end
      if (opb_be[0]) begin
        cfg0_data[15:8] <= opb_dbus[0:7];
      end
    end
    if (wr_en && reg_sel == REG_CFG1) begin
      if (opb_be[2]) begin
        cfg1_addr <= opb_dbus[20:23];
      end
      if (opb_be[1]) begin
        cfg1_data[7:0] <= opb_dbus[8:15];
      end
      if (opb_be[0]) begin
        cfg1_data[15:8] <= opb_dbus[0:7];
      end
    end
  end

  always_comb begin
    rd_word = '0;
    case (reg_sel)
      REG_CTRL: begin
        rd_word[2]  = adc1_psdone;
        rd_word[3]  = adc0_psdone;
        rd_word[10] = adc1_psincdec;
        rd_word[11] = adc1_psen;
        rd_word[14] = adc0_psincdec;
        rd_word[15] = adc0_psen;
      end
      REG_CFG0: begin
        rd_word[0:15]  = cfg0_data;
        rd_word[20:23] = cfg0_addr;
        rd_word[31]    = cfg0_done;
      end
      REG_CFG1: begin
        rd_word[0:15]  = cfg1_data;
        rd_word[20:23] = cfg1_addr;
        rd_word[31]    = cfg1_done;
      end
      default: begin
        rd_word = '0;
      end
    endcase
  end

  assign sl_dbus = sl_xferack ? rd_word : '0;

endmodule

`default_nettype wire
